// ==== test/dcache_trace.txt ====
// columns: op, word address, strobe, write data, expected read word (reads only)
// op upper digit is the test number, lower digit bit0 store, bit1 must hit, bit2 must miss
// cold read miss
24 00000123 0 00000000 a5a5048c
// back-to-back hits in the same line
32 00000120 0 00000000 a5a50480
32 00000121 0 00000000 a5a50484
32 00000127 0 00000000 a5a5049c
32 00000124 0 00000000 a5a50490
// partial stores, hit then miss
43 00000122 3 1234abcd 00000000
42 00000122 0 00000000 a5a5abcd
43 00000125 c deadbeef 00000000
42 00000125 0 00000000 dead0494
45 00000400 1 000000ff 00000000
42 00000400 0 00000000 a5a510ff
42 00000401 0 00000000 a5a51004
// lru in set 0x10 with tags 2, 3 and 5
54 00000881 0 00000000 a5a52204
55 00000c82 f 0badf00d 00000000
52 00000c82 0 00000000 0badf00d
52 00000881 0 00000000 a5a52204
54 00001480 0 00000000 a5a55200
52 00000881 0 00000000 a5a52204
54 00000c82 0 00000000 a5a53208
// op 00 ends the trace
00 00000000 0 00000000 00000000

// ==== dcache_top.f ====
+incdir+common
common/dcache_pkg.sv
common/lookup_if.sv
src/tag_lookup.sv
src/refill_ctrl.sv
src/data_stage.sv
src/dcache_top.sv
test/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - common

sources:
  - common/dcache_pkg.sv
  - common/lookup_if.sv
  - src/tag_lookup.sv
  - src/refill_ctrl.sv
  - src/data_stage.sv
  - src/dcache_top.sv
  - target: test
    files:
      - test/tb_dcache.sv

// ==== test/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;

    localparam int MAX_ENTRIES = 64;
    localparam int WAIT_LIMIT = 50;

    logic clk;
    logic rst;
    logic en_i;
    logic we_i;
    dcache_pkg::strb_t strb_i;
    dcache_pkg::addr_t addr_i;
    dcache_pkg::word_t wdata_i;
    dcache_pkg::word_t rdata_o;
    logic stall_o;
    logic mem_ren_o;
    logic [31:0] mem_raddr_o;
    logic mem_raccept_i;
    logic fill_valid_i;
    dcache_pkg::line_t fill_line_i;

    // five words per access in order op, address, strobe, write data and expected word
    logic [31:0] trace_mem [5*MAX_ENTRIES];
    integer seed;
    int bp_cycles;

    // read result due in the cycle after acceptance
    logic pending;
    dcache_pkg::word_t pending_exp;
    string pending_name;

    dcache_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .en_i          (en_i),
        .we_i          (we_i),
        .strb_i        (strb_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .rdata_o       (rdata_o),
        .stall_o       (stall_o),
        .mem_ren_o     (mem_ren_o),
        .mem_raddr_o   (mem_raddr_o),
        .mem_raccept_i (mem_raccept_i),
        .fill_valid_i  (fill_valid_i),
        .fill_line_i   (fill_line_i)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            fail_run($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic string test_name(input logic [3:0] num);
        case (num)
            4'd2: return "cold_read_miss";
            4'd3: return "back_to_back_hits";
            4'd4: return "store_strobes";
            4'd5: return "lru_eviction";
            default: return "trace";
        endcase
    endfunction

    // word at byte address A holds A xor a5a50000
    function automatic dcache_pkg::line_t rule_line(input logic [31:0] base);
        dcache_pkg::line_t line;
        logic [31:0] a;
        for (int i = 0; i < 8; i++) begin
            a = base + 32'(i * 4);
            line[i*32 +: 32] = a ^ 32'ha5a50000;
        end
        return line;
    endfunction

    // memory side of one miss that returns right after the fill edge
    task automatic serve_refill(input dcache_pkg::addr_t addr, input string name);
        logic [31:0] line_addr;
        int waits;
        int delay;
        int gap;
        line_addr = {addr[29:3], 5'b00000};
        waits = 0;
        while (!mem_ren_o) begin
            waits++;
            assert (waits < WAIT_LIMIT) else fail_run("timeout waiting for mem_ren_o on a miss");
            @(negedge clk);
        end
        check_word({name, " mem_raddr_o"}, line_addr, mem_raddr_o);
        delay = $unsigned($random(seed)) % 4;
        gap = 1 + $unsigned($random(seed)) % 3;
        // request must hold under back-pressure
        repeat (delay) begin
            @(negedge clk);
            assert (mem_ren_o && stall_o) else begin
                fail_run("mem_ren_o or stall_o dropped while mem_raccept_i was low");
            end
            check_word({name, " held mem_raddr_o"}, line_addr, mem_raddr_o);
            bp_cycles++;
        end
        @(posedge clk);
        mem_raccept_i <= 1'b1;
        @(posedge clk);
        mem_raccept_i <= 1'b0;
        repeat (gap - 1) @(posedge clk);
        fill_valid_i <= 1'b1;
        fill_line_i <= rule_line(line_addr);
        @(posedge clk);
        fill_valid_i <= 1'b0;
    endtask

    // test number in the upper op digit with bit0 store, bit1 must hit and bit2 must miss
    task automatic run_entry(input logic [7:0] op, input dcache_pkg::addr_t addr,
                             input dcache_pkg::strb_t strb, input dcache_pkg::word_t wdata,
                             input dcache_pkg::word_t exp);
        string name;
        int waits;
        logic missed;
        name = test_name(op[7:4]);
        en_i <= 1'b1;
        we_i <= op[0];
        strb_i <= strb;
        addr_i <= addr;
        wdata_i <= wdata;
        waits = 0;
        missed = 1'b0;
        @(negedge clk);
        if (pending) begin
            check_word(pending_name, pending_exp, rdata_o);
            pending = 1'b0;
        end
        // the access accepted last cycle hit, so memory stays idle
        assert (!mem_ren_o) else fail_run("memory request raised by an access that hit");
        while (stall_o) begin
            missed = 1'b1;
            assert (!op[1]) else fail_run({name, ": access missed where a hit was expected"});
            serve_refill(addr, name);
            waits++;
            assert (waits < 3) else fail_run("timeout waiting for stall_o to clear");
            @(negedge clk);
        end
        assert (missed || !op[2]) else fail_run({name, ": access hit where a miss was expected"});
        @(posedge clk);
        if (!op[0]) begin
            pending = 1'b1;
            pending_exp = exp;
            pending_name = name;
        end
    endtask

    initial begin : main
        int idx;
        clk = 1'b0;
        rst = 1'b1;
        en_i = 1'b0;
        we_i = 1'b0;
        strb_i = '0;
        addr_i = '0;
        wdata_i = '0;
        mem_raccept_i = 1'b0;
        fill_valid_i = 1'b0;
        fill_line_i = '0;
        seed = 32'h051d661a;
        bp_cycles = 0;
        pending = 1'b0;
        for (int i = 0; i < 5*MAX_ENTRIES; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("test/dcache_trace.txt", trace_mem);

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!mem_ren_o && !stall_o) else fail_run("mem_ren_o or stall_o high after reset");

        @(posedge clk);
        idx = 0;
        while (idx < MAX_ENTRIES && trace_mem[idx*5] != 0) begin
            run_entry(trace_mem[idx*5][7:0], trace_mem[idx*5+1][29:0], trace_mem[idx*5+2][3:0],
                      trace_mem[idx*5+3], trace_mem[idx*5+4]);
            idx++;
        end
        en_i <= 1'b0;
        we_i <= 1'b0;
        @(negedge clk);
        if (pending) begin
            check_word(pending_name, pending_exp, rdata_o);
            pending = 1'b0;
        end
        assert (!mem_ren_o) else fail_run("memory request raised by an access that hit");
        assert (idx > 0) else fail_run("trace file is empty or missing");
        assert (bp_cycles > 0) else fail_run("memory back-pressure was never exercised");
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                clk,
    input  logic                rst,

    // processor side
    input  logic                en_i,
    input  logic                we_i,
    input  dcache_pkg::strb_t   strb_i,
    input  dcache_pkg::addr_t   addr_i,
    input  dcache_pkg::word_t   wdata_i,
    output dcache_pkg::word_t   rdata_o,
    output logic                stall_o,

    // memory read side
    output logic                mem_ren_o,
    output logic [31:0]         mem_raddr_o,
    input  logic                mem_raccept_i,
    input  logic                fill_valid_i,
    input  dcache_pkg::line_t   fill_line_i
);

    logic miss;
    logic fill;

    lookup_if lk ();

    tag_lookup u_tag_lookup (
        .clk      (clk),
        .rst      (rst),
        .en_i     (en_i),
        .we_i     (we_i),
        .strb_i   (strb_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .fill_i   (fill),
        .miss_o   (miss),
        .stall_o  (stall_o),
        .lookup   (lk.lookup)
    );

    refill_ctrl u_refill_ctrl (
        .clk           (clk),
        .rst           (rst),
        .miss_i        (miss),
        .addr_i        (addr_i),
        .mem_raccept_i (mem_raccept_i),
        .fill_valid_i  (fill_valid_i),
        .mem_ren_o     (mem_ren_o),
        .mem_raddr_o   (mem_raddr_o),
        .fill_o        (fill)
    );

    // line from memory goes straight into the data array
    data_stage u_data_stage (
        .clk         (clk),
        .rst         (rst),
        .fill_line_i (fill_line_i),
        .lookup      (lk.data),
        .rdata_o     (rdata_o)
    );

endmodule

// ==== src/data_stage.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

module data_stage (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::line_t  fill_line_i,
    lookup_if.data             lookup,
    output dcache_pkg::word_t  rdata_o
);

    localparam int WORD_W = $bits(dcache_pkg::word_t);
    localparam int STRB_W = $bits(dcache_pkg::strb_t);

    // line storage of both ways
    dcache_pkg::line_t line_mem [`DCACHE_WAYS][`DCACHE_SETS];

    dcache_pkg::line_t cur_line;
    dcache_pkg::word_t cur_word;
    dcache_pkg::word_t merged_word;
    logic store;
    logic load;

    assign store = lookup.access && lookup.write;
    assign load = lookup.access && !lookup.write;

    // addressed word of the selected way
    assign cur_line = line_mem[lookup.way][lookup.index];
    assign cur_word = cur_line[lookup.offset*WORD_W +: WORD_W];

    // strobed bytes from the store, the rest kept
    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            if (lookup.strb[b]) begin
                merged_word[b*8 +: 8] = lookup.wdata[b*8 +: 8];
            end else begin
                merged_word[b*8 +: 8] = cur_word[b*8 +: 8];
            end
        end
    end

    // whole line on refill, one word on a store hit
    always_ff @(posedge clk) begin
        if (lookup.fill) begin
            line_mem[lookup.way][lookup.index] <= fill_line_i;
        end else if (store) begin
            line_mem[lookup.way][lookup.index][lookup.offset*WORD_W +: WORD_W] <= merged_word;
        end
    end

    // registered read port, holds between loads
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_o <= '0;
        end else if (load) begin
            rdata_o <= cur_word;
        end
    end

endmodule

// ==== src/refill_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

module refill_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               miss_i,
    input  dcache_pkg::addr_t  addr_i,
    input  logic               mem_raccept_i,
    input  logic               fill_valid_i,
    output logic               mem_ren_o,
    output logic [31:0]        mem_raddr_o,
    output logic               fill_o
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } state_t;

    state_t state_q;

    // fill beat only counts while a line is outstanding
    assign fill_o = (state_q == WAIT) && fill_valid_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            mem_ren_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (miss_i) begin
                        mem_ren_o <= 1'b1;
                        state_q <= REQ;
                    end
                end
                REQ: begin
                    // held until memory takes the request
                    if (mem_raccept_i) begin
                        mem_ren_o <= 1'b0;
                        state_q <= WAIT;
                    end
                end
                WAIT: begin
                    if (fill_valid_i) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // line-aligned byte address, captured when the request goes out
    always_ff @(posedge clk) begin
        if (state_q == IDLE && miss_i) begin
            mem_raddr_o <= {addr_i[$bits(dcache_pkg::addr_t)-1:`DCACHE_OFFSET_W],
                            {(`DCACHE_OFFSET_W + 2){1'b0}}};
        end
    end

endmodule

// ==== src/tag_lookup.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

module tag_lookup (
    input  logic               clk,
    input  logic               rst,
    input  logic               en_i,
    input  logic               we_i,
    input  dcache_pkg::strb_t  strb_i,
    input  dcache_pkg::addr_t  addr_i,
    input  dcache_pkg::word_t  wdata_i,
    input  logic               fill_i,
    output logic               miss_o,
    output logic               stall_o,
    lookup_if.lookup           lookup
);

    dcache_pkg::tag_t tag;
    dcache_pkg::index_t index;
    dcache_pkg::offset_t offset;

    // tag and valid state per way and set
    dcache_pkg::tag_t tag_q [`DCACHE_WAYS][`DCACHE_SETS];
    logic valid_q [`DCACHE_WAYS][`DCACHE_SETS];

    // 1 means way 0 is the next victim
    logic [`DCACHE_SETS-1:0] lru_q;

    logic [`DCACHE_WAYS-1:0] hit;
    logic hit_any;
    dcache_pkg::way_t victim;

    assign {tag, index, offset} = addr_i;

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
        end
    end

    assign hit_any = |hit;
    assign victim = ~lru_q[index];

    // an enabled miss holds the processor until the refill lands
    assign miss_o = en_i && !hit_any;
    assign stall_o = miss_o;

    // request handed to the data array, same cycle
    assign lookup.access = en_i && hit_any;
    assign lookup.write = we_i;
    assign lookup.fill = fill_i;
    assign lookup.way = fill_i ? victim : dcache_pkg::way_t'(hit[1]);
    assign lookup.index = index;
    assign lookup.offset = offset;
    assign lookup.strb = strb_i;
    assign lookup.wdata = wdata_i;

    // refill installs the tag in the victim way
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                for (int s = 0; s < `DCACHE_SETS; s++) begin
                    tag_q[w][s] <= '0;
                    valid_q[w][s] <= 1'b0;
                end
            end
        end else if (fill_i) begin
            tag_q[victim][index] <= tag;
            valid_q[victim][index] <= 1'b1;
        end
    end

    // hit in way 0 points the victim at way 1 and the other way round
    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q <= '1;
        end else if (lookup.access) begin
            lru_q[index] <= hit[1];
        end
    end

endmodule

// ==== common/lookup_if.sv ====
`timescale 1ns/1ps

interface lookup_if;

    logic access;
    logic write;
    logic fill;
    dcache_pkg::way_t way;
    dcache_pkg::index_t index;
    dcache_pkg::offset_t offset;
    dcache_pkg::strb_t strb;
    dcache_pkg::word_t wdata;

    // tag stage side
    modport lookup (
        output access, write, fill, way, index, offset, strb, wdata
    );

    // data array side
    modport data (
        input access, write, fill, way, index, offset, strb, wdata
    );

endinterface

// ==== common/dcache_pkg.sv ====
`include "dcache_macros.svh"

package dcache_pkg;

    // processor data path
    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;

    // word address, 30 bits of a 32-bit byte address
    typedef logic [`DCACHE_TAG_W+`DCACHE_INDEX_W+`DCACHE_OFFSET_W-1:0] addr_t;

    // address fields
    typedef logic [`DCACHE_TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    // one full line as delivered by a refill
    typedef logic [`DCACHE_WORDS*32-1:0] line_t;

    // way select, 0 or 1
    typedef logic way_t;

endpackage

// ==== common/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry
`define DCACHE_WAYS 2
`define DCACHE_SETS 128

// word address split, tag | index | offset
`define DCACHE_INDEX_W 7
`define DCACHE_OFFSET_W 3
`define DCACHE_TAG_W 20

// words per line
`define DCACHE_WORDS 8

`endif
